// ==== design/bpu_pkg.sv ====
package bpu_pkg;

    //////////////////////////////
    // Geometry
    //////////////////////////////

    // Address width of fetch and resolve ports
    localparam int unsigned addr_w = 32;

    // Direct mapped BTB indexed by pc[10:2]
    localparam int unsigned btb_index_w = 9;
    localparam int unsigned btb_depth = 1 << btb_index_w;
    // Partial tag of pc[30:28] then pc[19:11]
    localparam int unsigned btb_tag_w = 12;

    // BHT index from pc[11:2]
    localparam int unsigned bht_index_w = 10;
    localparam int unsigned bht_depth = 1 << bht_index_w;

    // Two slots per fetch pair
    localparam int unsigned fetch_width = 2;
    // Sequential step of one pair
    localparam int unsigned fetch_bytes = 8;

    // Two-bit direction counter
    typedef logic [1:0] ctr_t;
    // Weakly not taken, upper bit set means taken
    localparam ctr_t ctr_reset = 2'b01;

    //////////////////////////////
    // Bundles
    //////////////////////////////

    // Slot 0 is the older instruction
    typedef struct packed {
        logic [addr_w-1:0] pc0;
        logic [addr_w-1:0] pc1;
    } fetch_pair_t;

    // Resolved branch from the execute side
    typedef struct packed {
        logic [addr_w-1:0] pc;
        logic [addr_w-1:0] target;
        logic              taken;
    } bpu_update_t;

    // Per-slot BTB result with zero target on a miss
    typedef struct packed {
        logic              hit;
        logic [addr_w-1:0] target;
    } btb_hit_t;

    typedef struct packed {
        logic              redirect;
        logic              taken_slot;
        logic [addr_w-1:0] next_pc;
    } fetch_pred_t;

    //////////////////////////////
    // Address slicing
    //////////////////////////////

    function automatic logic [btb_index_w-1:0] btb_index_of(input logic [addr_w-1:0] a);
        return a[btb_index_w+1:2];
    endfunction

    function automatic logic [btb_tag_w-1:0] btb_tag_of(input logic [addr_w-1:0] a);
        return {a[30:28], a[19:11]};
    endfunction

    function automatic logic [bht_index_w-1:0] bht_index_of(input logic [addr_w-1:0] a);
        return a[bht_index_w+1:2];
    endfunction

endpackage

// ==== design/btb_dual.sv ====
module btb_dual (
    input  logic                                       clk,
    input  logic                                       rst,
    input  bpu_pkg::fetch_pair_t                       fetch,
    input  logic                                       upd_en,
    input  bpu_pkg::bpu_update_t                       upd,
    output bpu_pkg::btb_hit_t [bpu_pkg::fetch_width-1:0] hits
);
    import bpu_pkg::*;

    // Stored payload of one entry
    typedef struct packed {
        logic [btb_tag_w-1:0] tag;
        logic [addr_w-1:0]    target;
    } btb_entry_t;

    //////////////////////////////
    // Storage
    //////////////////////////////

    // One valid bit per entry
    logic [btb_depth-1:0] valid;
    btb_entry_t           entry [btb_depth];

    // Per-slot lookup fields
    logic [addr_w-1:0]      slot_pc [fetch_width];
    logic [btb_index_w-1:0] rd_idx  [fetch_width];
    logic [btb_tag_w-1:0]   rd_tag  [fetch_width];

    // Write side
    logic [btb_index_w-1:0] wr_idx;
    logic                   wr_en;

    assign slot_pc[0] = fetch.pc0;
    assign slot_pc[1] = fetch.pc1;

    always_comb begin
        for (int s = 0; s < fetch_width; s++) begin
            rd_idx[s] = btb_index_of(slot_pc[s]);
            rd_tag[s] = btb_tag_of(slot_pc[s]);
        end
    end

    // Only taken branches allocate
    assign wr_en  = upd_en && upd.taken;
    assign wr_idx = btb_index_of(upd.pc);

    //////////////////////////////
    // Update
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
        end else if (wr_en) begin
            valid[wr_idx] <= 1'b1;
        end
    end

    // Plain overwrite of whatever sat at this index
    always_ff @(posedge clk) begin
        if (wr_en) begin
            entry[wr_idx] <= '{tag: btb_tag_of(upd.pc), target: upd.target};
        end
    end

    //////////////////////////////
    // Lookup
    //////////////////////////////

    // Reads see the array before a same-edge write
    always_ff @(posedge clk) begin
        if (rst) begin
            hits <= '0;
        end else begin
            for (int s = 0; s < fetch_width; s++) begin
                if (valid[rd_idx[s]] && (entry[rd_idx[s]].tag == rd_tag[s])) begin
                    hits[s].hit    <= 1'b1;
                    hits[s].target <= entry[rd_idx[s]].target;
                end else begin
                    hits[s] <= '0;
                end
            end
        end
    end

    // Resolve stage must hand over a clean branch address
    a_upd_pc_known: assert property (@(posedge clk) disable iff (rst)
        upd_en |-> !$isunknown(upd.pc));

endmodule

// ==== design/bht_dual.sv ====
module bht_dual (
    input  logic                             clk,
    input  logic                             rst,
    input  bpu_pkg::fetch_pair_t             fetch,
    input  logic                             upd_en,
    input  bpu_pkg::bpu_update_t             upd,
    output logic [bpu_pkg::fetch_width-1:0]  taken_pred
);
    import bpu_pkg::*;

    //////////////////////////////
    // Counter table
    //////////////////////////////

    ctr_t ctr [bht_depth];

    // Read indices, one per slot
    logic [bht_index_w-1:0] rd_idx [fetch_width];

    // Counter under update and its next value
    logic [bht_index_w-1:0] upd_idx;
    ctr_t                   upd_ctr;
    ctr_t                   ctr_step;

    assign rd_idx[0] = bht_index_of(fetch.pc0);
    assign rd_idx[1] = bht_index_of(fetch.pc1);

    assign upd_idx = bht_index_of(upd.pc);
    assign upd_ctr = ctr[upd_idx];

    // One step toward the outcome
    always_comb begin
        ctr_step = upd_ctr;
        if (upd.taken) begin
            // Hold at strongly taken
            if (upd_ctr != 2'b11) begin
                ctr_step = upd_ctr + 2'd1;
            end
        end else begin
            // Hold at strongly not taken
            if (upd_ctr != 2'b00) begin
                ctr_step = upd_ctr - 2'd1;
            end
        end
    end

    // Every resolved branch trains the counter
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < bht_depth; i++) begin
                ctr[i] <= ctr_reset;
            end
        end else if (upd_en) begin
            ctr[upd_idx] <= ctr_step;
        end
    end

    //////////////////////////////
    // Prediction
    //////////////////////////////

    // Upper counter bit as seen before a same-edge update
    always_ff @(posedge clk) begin
        if (rst) begin
            taken_pred <= '0;
        end else begin
            for (int s = 0; s < fetch_width; s++) begin
                taken_pred[s] <= ctr[rd_idx[s]][1];
            end
        end
    end

    // A trained counter never wraps past either end
    a_ctr_no_wrap: assert property (@(posedge clk) disable iff (rst)
        upd_en |=> ($past(upd.taken) ? (ctr[$past(upd_idx)] >= $past(upd_ctr))
                                     : (ctr[$past(upd_idx)] <= $past(upd_ctr))));

endmodule

// ==== design/npc_select.sv ====
module npc_select (
    input  logic                                         clk,
    input  logic                                         rst,
    input  bpu_pkg::fetch_pair_t                         fetch,
    input  bpu_pkg::btb_hit_t [bpu_pkg::fetch_width-1:0] hits,
    input  logic [bpu_pkg::fetch_width-1:0]              taken_pred,
    output bpu_pkg::fetch_pred_t                         pred
);
    import bpu_pkg::*;

    //////////////////////////////
    // Pair alignment
    //////////////////////////////

    // Fall-through address of the pair in the lookup stage
    logic [addr_w-1:0] seq_pc_q;

    // Per-slot taken decision
    logic [fetch_width-1:0] slot_taken;

    // Sequential address formed ahead of the register
    always_ff @(posedge clk) begin
        if (rst) begin
            seq_pc_q <= '0;
        end else begin
            seq_pc_q <= fetch.pc0 + addr_w'(fetch_bytes);
        end
    end

    //////////////////////////////
    // Next fetch address
    //////////////////////////////

    // Known branch and counter says taken
    always_comb begin
        for (int s = 0; s < fetch_width; s++) begin
            slot_taken[s] = hits[s].hit && taken_pred[s];
        end
    end

    // Older slot wins
    always_comb begin
        pred          = '0;
        pred.next_pc  = seq_pc_q;
        if (slot_taken[0]) begin
            pred.redirect   = 1'b1;
            pred.taken_slot = 1'b0;
            pred.next_pc    = hits[0].target;
        end else if (slot_taken[1]) begin
            pred.redirect   = 1'b1;
            pred.taken_slot = 1'b1;
            pred.next_pc    = hits[1].target;
        end
    end

    // Fetch reads taken_slot only on a redirect
    a_slot_idle: assert property (@(posedge clk) disable iff (rst)
        !pred.redirect |-> !pred.taken_slot);

endmodule

// ==== design/bpu_top.sv ====
module bpu_top (
    input  logic                 clk,
    input  logic                 rst,
    input  bpu_pkg::fetch_pair_t fetch,
    input  logic                 upd_en,
    input  bpu_pkg::bpu_update_t upd,
    output bpu_pkg::fetch_pred_t pred
);
    import bpu_pkg::*;

    // Table results one cycle after the pair is sampled
    btb_hit_t [fetch_width-1:0] hits;
    logic [fetch_width-1:0]     taken_pred;

    //////////////////////////////
    // Tables side by side
    //////////////////////////////

    btb_dual btb_dual_i (
        .clk    (clk),
        .rst    (rst),
        .fetch  (fetch),
        .upd_en (upd_en),
        .upd    (upd),
        .hits   (hits)
    );

    bht_dual bht_dual_i (
        .clk        (clk),
        .rst        (rst),
        .fetch      (fetch),
        .upd_en     (upd_en),
        .upd        (upd),
        .taken_pred (taken_pred)
    );

    // Merge into the next fetch address
    npc_select npc_select_i (
        .clk        (clk),
        .rst        (rst),
        .fetch      (fetch),
        .hits       (hits),
        .taken_pred (taken_pred),
        .pred       (pred)
    );

endmodule

// ==== tests/bpu_tb.sv ====
module bpu_tb;
    import bpu_pkg::*;

    // Upper bound on lines taken from the stimulus file
    localparam int max_lines = 1000;
    localparam string input_path = "tests/bpu_input.txt";

    logic        clk;
    logic        rst;
    fetch_pair_t fetch;
    logic        upd_en;
    bpu_update_t upd;
    fetch_pred_t pred;

    // Expectation of the record driven one cycle earlier
    fetch_pred_t exp_q;
    logic        exp_live;
    int          exp_line;

    int checks;
    int value_errors;
    int other_errors;

    bpu_top bpu_top_i (
        .clk    (clk),
        .rst    (rst),
        .fetch  (fetch),
        .upd_en (upd_en),
        .upd    (upd),
        .pred   (pred)
    );

    //////////////////////////////
    // Clock
    //////////////////////////////

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    //////////////////////////////
    // Helpers
    //////////////////////////////

    // Idle bus with no update
    task automatic drive_idle();
        fetch  = '0;
        upd_en = 1'b0;
        upd    = '0;
    endtask

    // Each field of the prediction on its own
    task automatic compare_pred(input fetch_pred_t exp, input int line_no);
        checks++;
        assert (pred.redirect === exp.redirect) else begin
            $display("Fail at %0t: line %0d redirect is %0b, expected %0b",
                     $time, line_no, pred.redirect, exp.redirect);
            value_errors++;
        end
        assert (pred.taken_slot === exp.taken_slot) else begin
            $display("Fail at %0t: line %0d taken_slot is %0b, expected %0b",
                     $time, line_no, pred.taken_slot, exp.taken_slot);
            value_errors++;
        end
        assert (pred.next_pc === exp.next_pc) else begin
            $display("Fail at %0t: line %0d next_pc is %h, expected %h",
                     $time, line_no, pred.next_pc, exp.next_pc);
            value_errors++;
        end
    endtask

    //////////////////////////////
    // Stimulus and checking
    //////////////////////////////

    initial begin
        int          fd;
        int          lines;
        int          n;
        bit          done;
        string       line;
        logic [31:0] f_pc0;
        logic [31:0] f_pc1;
        logic [31:0] f_en;
        logic [31:0] f_upc;
        logic [31:0] f_utgt;
        logic [31:0] f_utaken;
        logic [31:0] f_redir;
        logic [31:0] f_slot;
        logic [31:0] f_next;

        rst = 1'b1;
        drive_idle();
        checks = 0;
        value_errors = 0;
        other_errors = 0;
        exp_live = 1'b0;
        exp_q = '0;
        exp_line = 0;

        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        // Straight out of reset nothing has been looked up yet
        compare_pred('0, 0);

        fd = $fopen(input_path, "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file %s", input_path);
            other_errors++;
        end else begin
            lines = 0;
            done = 1'b0;
            while (!done) begin
                if ($fgets(line, fd) == 0) begin
                    done = 1'b1;
                end else begin
                    lines++;
                    if (lines > max_lines) begin
                        $display("Stimulus file still running after %0d lines, giving up",
                                 max_lines);
                        other_errors++;
                        done = 1'b1;
                    end else if (line.len() > 1 && line[0] != "#") begin
                        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h", f_pc0, f_pc1,
                                    f_en, f_upc, f_utgt, f_utaken, f_redir, f_slot, f_next);
                        if (n != 9) begin
                            $display("Line %0d of the stimulus file has %0d fields, not 9",
                                     lines, n);
                            other_errors++;
                        end else begin
                            @(posedge clk);
                            #1;
                            // Result of the previous record is settled by now
                            if (exp_live) begin
                                compare_pred(exp_q, exp_line);
                            end
                            fetch.pc0  = f_pc0;
                            fetch.pc1  = f_pc1;
                            upd_en     = f_en[0];
                            upd.pc     = f_upc;
                            upd.target = f_utgt;
                            upd.taken  = f_utaken[0];
                            exp_q.redirect   = f_redir[0];
                            exp_q.taken_slot = f_slot[0];
                            exp_q.next_pc    = f_next;
                            exp_line = lines;
                            exp_live = 1'b1;
                        end
                    end
                end
            end
            $fclose(fd);

            // Last record still in flight
            @(posedge clk);
            #1;
            if (exp_live) begin
                compare_pred(exp_q, exp_line);
            end
            drive_idle();
            if (checks < 2) begin
                $display("The stimulus file held no usable records");
                other_errors++;
            end
        end

        $display("Checks %0d, value errors %0d, other errors %0d",
                 checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== tests/bpu_input.txt ====
# pc0 pc1 upd_en upd_pc upd_target upd_taken | exp_redirect exp_taken_slot exp_next_pc
# expected columns apply to the pair on this line, checked one cycle later
00000100 00000104 0 00000000 00000000 0 0 0 00000108
00000200 00000204 0 00000000 00000000 0 0 0 00000208
00001040 00001044 1 00001040 00002000 1 0 0 00001048
00001040 00001044 0 00000000 00000000 0 1 0 00002000
0000103c 00001040 1 00001044 00003000 1 1 1 00002000
00001040 00001044 0 00000000 00000000 0 1 0 00002000
00001100 00001044 0 00000000 00000000 0 1 1 00003000
00001040 00001044 1 00001040 00002000 1 1 0 00002000
00001040 00001044 1 00001040 00000000 0 1 0 00002000
00001040 00001044 1 00001040 00000000 0 1 0 00002000
00001040 00001048 0 00000000 00000000 0 0 0 00001048
00001040 00001044 0 00000000 00000000 0 1 1 00003000
00000400 00000404 1 00001840 00004000 1 0 0 00000408
00001840 00001844 1 00001040 00002000 1 1 0 00004000
00001840 00001848 0 00000000 00000000 0 0 0 00001848
00001040 00001048 0 00000000 00000000 0 1 0 00002000
00000500 00000504 1 00001840 00004000 1 0 0 00000508
00001840 00001848 0 00000000 00000000 0 1 0 00004000
00001040 00001048 0 00000000 00000000 0 0 0 00001048

// ==== bpu.f ====
design/bpu_pkg.sv
design/btb_dual.sv
design/bht_dual.sv
design/npc_select.sv
design/bpu_top.sv
tests/bpu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the branch predictor testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f bpu.f --top-module bpu_tb -o bpu_sim \
    && ./obj_dir/bpu_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation run failed"; exit 1; }

cat sim.log

grep -q "TEST RESULT: FAIL" sim.log \
    && { echo "Simulation reported failure"; exit 1; } \
    || { echo "Simulation finished without failure"; exit 0; }
